//--- all.f
logic/na_pkg.sv
logic/na_noc_buffer.sv
logic/na_wb_decode.sv
logic/na_conf_regs.sv
logic/na_mp_send.sv
logic/na_mp_recv.sv
logic/na_top.sv
sim/na_tb.sv

//--- logic/na_conf_regs.sv
/*
 * Configuration window: tile identity, core base and interrupt enable
 */

`timescale 1ns/1ps

module na_conf_regs #(
   parameter logic [31:0] TILE_ID   = 32'h0,
   parameter logic [31:0] CORE_BASE = 32'h0
) (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            sel_i,
   input  na_pkg::wb_req_t req_i,
   output na_pkg::wb_rsp_t rsp_o,
   input  logic            pending_i,
   output logic            irq_o
);

   import na_pkg::*;

   wb_state_e state_q;
   wb_addr_t  offs;
   wb_data_t  rdata_q;
   logic      irq_en_q;
   logic      access;

   assign offs   = {4'h0, req_i.adr[19:0]};
   assign access = sel_i & (state_q == WB_IDLE);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= WB_IDLE;
         irq_en_q <= 1'b0;
      end else begin
         state_q <= access ? WB_RESPOND : WB_IDLE;   // Ack lasts one cycle
         if (access && req_i.we && offs == REG_IRQ_EN)
            irq_en_q <= req_i.dat[0];
      end
   end

   always_ff @(posedge clk_i) begin
      case (offs)
         REG_TILEID:   rdata_q <= TILE_ID;
         REG_COREBASE: rdata_q <= CORE_BASE;
         REG_IRQ_EN:   rdata_q <= {31'b0, irq_en_q};
         default:      rdata_q <= '0;
      endcase
   end

   always_comb begin
      rsp_o.ack = (state_q == WB_RESPOND);
      rsp_o.err = 1'b0;
      rsp_o.dat = rsp_o.ack ? rdata_q : '0;
   end

   assign irq_o = pending_i & irq_en_q;   // Level interrupt

endmodule

//--- logic/na_mp_recv.sv
/*
 * Message receive path: flit queue with a complete-packet count
 * The core pops flits one by one through the data register
 */

`timescale 1ns/1ps

module na_mp_recv #(
   parameter int RECV_DEPTH = 16
) (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              sel_i,
   input  na_pkg::wb_req_t   req_i,
   output na_pkg::wb_rsp_t   rsp_o,
   input  na_pkg::noc_flit_t in_flit_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   output logic              pending_o
);

   import na_pkg::*;

   localparam int AW = (RECV_DEPTH > 1) ? $clog2(RECV_DEPTH) : 1;
   localparam int CW = $clog2(RECV_DEPTH + 1);

   noc_flit_t     mem [RECV_DEPTH];
   noc_flit_t     head;
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] fill_q;
   logic [CW-1:0] pkt_q;     // Packets whose last flit is queued
   wb_state_e     state_q;
   logic          err_q;
   wb_data_t      rdata_q;
   logic          rd_req;
   logic          offs_data;
   logic          offs_status;
   logic          push;
   logic          pop;

   assign head        = mem[rd_ptr_q];
   assign offs_data   = ({4'h0, req_i.adr[19:0]} == REG_MP_DATA);
   assign offs_status = ({4'h0, req_i.adr[19:0]} == REG_MP_STATUS);
   assign rd_req      = sel_i & ~req_i.we & (state_q == WB_IDLE);

   assign in_ready_o = (fill_q != CW'(RECV_DEPTH));
   assign push       = in_valid_i & in_ready_o;
   assign pop        = rd_req & offs_data & (fill_q != '0);
   assign pending_o  = (pkt_q != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         pkt_q    <= '0;
         state_q  <= WB_IDLE;
         err_q    <= 1'b0;
      end else begin
         if (push)
            wr_ptr_q <= (wr_ptr_q == AW'(RECV_DEPTH - 1)) ? '0 : wr_ptr_q + AW'(1);
         if (pop)
            rd_ptr_q <= (rd_ptr_q == AW'(RECV_DEPTH - 1)) ? '0 : rd_ptr_q + AW'(1);
         case ({push, pop})
            2'b10:   fill_q <= fill_q + CW'(1);
            2'b01:   fill_q <= fill_q - CW'(1);
            default: fill_q <= fill_q;
         endcase
         case ({push & in_flit_i.last, pop & head.last})
            2'b10:   pkt_q <= pkt_q + CW'(1);
            2'b01:   pkt_q <= pkt_q - CW'(1);
            default: pkt_q <= pkt_q;
         endcase
         state_q <= rd_req ? WB_RESPOND : WB_IDLE;
         err_q   <= rd_req & ~pop & ~offs_status;   // Empty queue or unknown offset
      end
   end

   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr_q] <= in_flit_i;
      if (pop)
         rdata_q <= head.data;
      else
         rdata_q <= wb_data_t'(pkt_q);
   end

   always_comb begin
      rsp_o.ack = (state_q == WB_RESPOND) & ~err_q;
      rsp_o.err = (state_q == WB_RESPOND) & err_q;
      rsp_o.dat = rsp_o.ack ? rdata_q : '0;   // Zero when idle, shares the window
   end

endmodule

//--- logic/na_mp_send.sv
/*
 * Message send path: a length word, then one bus write per flit
 * Ack on a data write waits until the flit has left for the link buffer
 */

`timescale 1ns/1ps

module na_mp_send (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              sel_i,
   input  na_pkg::wb_req_t   req_i,
   output na_pkg::wb_rsp_t   rsp_o,
   output na_pkg::noc_flit_t out_flit_o,
   output logic              out_valid_o,
   input  logic              out_ready_i
);

   import na_pkg::*;

   localparam int CNT_W = $clog2(MAX_PKT_LEN + 1);

   wb_state_e        state_q;
   logic             err_q;
   logic [CNT_W-1:0] remain_q;   // Flits still owed for the current packet
   logic             wr_req;
   logic             offs_data;
   logic             len_ok;

   assign wr_req    = sel_i & req_i.we & (state_q == WB_IDLE);
   assign offs_data = ({4'h0, req_i.adr[19:0]} == REG_MP_DATA);
   assign len_ok    = (req_i.dat != '0) && (req_i.dat <= MAX_PKT_LEN);

   // Flit goes out straight from the held bus request
   assign out_valid_o     = wr_req & offs_data & (remain_q != '0);
   assign out_flit_o.data = req_i.dat;
   assign out_flit_o.last = (remain_q == CNT_W'(1));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= WB_IDLE;
         err_q    <= 1'b0;
         remain_q <= '0;
      end else begin
         state_q <= WB_IDLE;
         if (wr_req) begin
            if (!offs_data) begin
               state_q <= WB_RESPOND;   // Status is read only
               err_q   <= 1'b1;
            end else if (remain_q == '0) begin
               // Length word
               state_q <= WB_RESPOND;
               err_q   <= ~len_ok;
               if (len_ok)
                  remain_q <= CNT_W'(req_i.dat);
            end else if (out_ready_i) begin
               state_q  <= WB_RESPOND;
               err_q    <= 1'b0;
               remain_q <= remain_q - CNT_W'(1);
            end
         end
      end
   end

   always_comb begin
      rsp_o.dat = '0;   // Write only
      rsp_o.ack = (state_q == WB_RESPOND) & ~err_q;
      rsp_o.err = (state_q == WB_RESPOND) & err_q;
   end

endmodule

//--- logic/na_noc_buffer.sv
/*
 * Link buffer: circular flit FIFO with valid/ready on both sides
 */

`timescale 1ns/1ps

module na_noc_buffer #(
   parameter int DEPTH = 4
) (
   input  logic              clk_i,
   input  logic              reset_i,
   input  na_pkg::noc_flit_t in_flit_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   output na_pkg::noc_flit_t out_flit_o,
   output logic              out_valid_o,
   input  logic              out_ready_i
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   na_pkg::noc_flit_t mem [DEPTH];
   logic [AW-1:0]     wr_ptr_q;
   logic [AW-1:0]     rd_ptr_q;
   logic [CW-1:0]     fill_q;
   logic [CW-1:0]     fill_d;
   logic              rdy_q;
   logic              push;
   logic              pop;

   assign in_ready_o  = rdy_q;   // Low in reset, up one cycle later
   assign out_valid_o = (fill_q != '0);
   assign out_flit_o  = mem[rd_ptr_q];
   assign push        = in_valid_i & rdy_q;
   assign pop         = out_valid_o & out_ready_i;

   always_comb begin
      fill_d = fill_q;
      if (push && !pop)
         fill_d = fill_q + CW'(1);
      else if (pop && !push)
         fill_d = fill_q - CW'(1);
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         rdy_q    <= 1'b0;
      end else begin
         fill_q <= fill_d;
         rdy_q  <= (fill_d != CW'(DEPTH));   // Full next cycle blocks the input
         if (push)
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + AW'(1);
         if (pop)
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + AW'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr_q] <= in_flit_i;
   end

endmodule

//--- logic/na_pkg.sv
/*
 * Network adapter shared types: flit and bus structs, address map, widths
 */

package na_pkg;

   typedef logic [31:0] flit_data_t;   // Payload of one flit
   typedef logic [23:0] wb_addr_t;     // Slave address inside the adapter
   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  win_sel_t;     // Address bits 23:20

   typedef struct packed {
      logic       last;
      flit_data_t data;
   } noc_flit_t;

   // Request from the core, held until ack or err
   typedef struct packed {
      wb_addr_t adr;
      wb_data_t dat;
      logic     we;
      logic     cyc;
      logic     stb;
   } wb_req_t;

   typedef struct packed {
      wb_data_t dat;
      logic     ack;
      logic     err;
   } wb_rsp_t;

   // Slave windows
   localparam win_sel_t WIN_CONF = 4'h0;
   localparam win_sel_t WIN_MP   = 4'h1;

   // Configuration window offsets
   localparam wb_addr_t REG_TILEID   = 24'h00_0000;
   localparam wb_addr_t REG_COREBASE = 24'h00_0004;
   localparam wb_addr_t REG_IRQ_EN   = 24'h00_0008;

   // Message window offsets
   localparam wb_addr_t REG_MP_DATA   = 24'h00_0000;
   localparam wb_addr_t REG_MP_STATUS = 24'h00_0004;

   localparam int MAX_PKT_LEN = 16;   // Largest length word accepted

   // One-cycle acknowledge of the slave modules
   typedef enum logic {
      WB_IDLE,
      WB_RESPOND
   } wb_state_e;

endpackage

//--- logic/na_top.sv
/*
 * Compute tile network adapter: bus slave with configuration window,
 * message send and receive endpoint, one buffered link in each direction
 */

`timescale 1ns/1ps

module na_top #(
   parameter logic [31:0] TILE_ID    = 32'h0000_0001,
   parameter logic [31:0] CORE_BASE  = 32'h0000_0000,
   parameter int          BUF_DEPTH  = 4,
   parameter int          RECV_DEPTH = 16
) (
   input  logic              clk_i,
   input  logic              reset_i,
   input  na_pkg::wb_req_t   wb_req_i,
   output na_pkg::wb_rsp_t   wb_rsp_o,
   input  na_pkg::noc_flit_t noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output na_pkg::noc_flit_t noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,
   output logic              irq_o
);

   import na_pkg::*;

   logic      conf_sel;
   logic      mp_sel;
   logic      send_sel;
   logic      recv_sel;
   wb_rsp_t   conf_rsp;
   wb_rsp_t   mp_rsp;
   wb_rsp_t   send_rsp;
   wb_rsp_t   recv_rsp;
   logic      pending;

   noc_flit_t send_flit;
   logic      send_valid;
   logic      send_ready;
   noc_flit_t recv_flit;
   logic      recv_valid;
   logic      recv_ready;

   // Message window, writes go to send, reads to receive
   assign send_sel = mp_sel & wb_req_i.we;
   assign recv_sel = mp_sel & ~wb_req_i.we;
   assign mp_rsp   = wb_rsp_t'(send_rsp | recv_rsp);   // Only one side responds

   na_wb_decode u_decode (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (wb_req_i),
      .rsp_o      (wb_rsp_o),
      .conf_sel_o (conf_sel),
      .mp_sel_o   (mp_sel),
      .conf_rsp_i (conf_rsp),
      .mp_rsp_i   (mp_rsp)
   );

   na_conf_regs #(
      .TILE_ID   (TILE_ID),
      .CORE_BASE (CORE_BASE)
   ) u_conf (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .sel_i     (conf_sel),
      .req_i     (wb_req_i),
      .rsp_o     (conf_rsp),
      .pending_i (pending),
      .irq_o     (irq_o)
   );

   na_mp_send u_send (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .sel_i       (send_sel),
      .req_i       (wb_req_i),
      .rsp_o       (send_rsp),
      .out_flit_o  (send_flit),
      .out_valid_o (send_valid),
      .out_ready_i (send_ready)
   );

   na_mp_recv #(
      .RECV_DEPTH (RECV_DEPTH)
   ) u_recv (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .sel_i      (recv_sel),
      .req_i      (wb_req_i),
      .rsp_o      (recv_rsp),
      .in_flit_i  (recv_flit),
      .in_valid_i (recv_valid),
      .in_ready_o (recv_ready),
      .pending_o  (pending)
   );

   na_noc_buffer #(.DEPTH(BUF_DEPTH)) u_outbuffer (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_flit_i   (send_flit),
      .in_valid_i  (send_valid),
      .in_ready_o  (send_ready),
      .out_flit_o  (noc_out_flit_o),
      .out_valid_o (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i)
   );

   na_noc_buffer #(.DEPTH(BUF_DEPTH)) u_inbuffer (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_flit_i   (noc_in_flit_i),
      .in_valid_i  (noc_in_valid_i),
      .in_ready_o  (noc_in_ready_o),
      .out_flit_o  (recv_flit),
      .out_valid_o (recv_valid),
      .out_ready_i (recv_ready)
   );

endmodule

//--- logic/na_wb_decode.sv
/*
 * Bus decoder of the adapter slave port
 * Selects the configuration or message window, errors on anything else
 */

`timescale 1ns/1ps

module na_wb_decode (
   input  logic            clk_i,
   input  logic            reset_i,
   input  na_pkg::wb_req_t req_i,
   output na_pkg::wb_rsp_t rsp_o,
   output logic            conf_sel_o,
   output logic            mp_sel_o,
   input  na_pkg::wb_rsp_t conf_rsp_i,
   input  na_pkg::wb_rsp_t mp_rsp_i
);

   import na_pkg::*;

   win_sel_t win;
   logic     req_valid;
   logic     unmapped;
   logic     err_q;

   assign win       = req_i.adr[23:20];
   assign req_valid = req_i.cyc & req_i.stb;

   assign conf_sel_o = req_valid & (win == WIN_CONF);
   assign mp_sel_o   = req_valid & (win == WIN_MP);
   assign unmapped   = req_valid & (win != WIN_CONF) & (win != WIN_MP);

   // Err for a gap in the map, one pulse per request
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= unmapped & ~err_q;
      end
   end

   // Response follows the window of the pending request
   always_comb begin
      rsp_o = '0;
      case (win)
         WIN_CONF: rsp_o = conf_rsp_i;
         WIN_MP:   rsp_o = mp_rsp_i;
         default:  rsp_o.err = err_q;
      endcase
   end

endmodule

//--- run.sh
#!/bin/sh
# Build the network adapter testbench with Verilator, run it, check the log

verilator --binary --timing --assert -f all.f --top-module na_tb > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vna_tb > sim.log 2>&1 ; cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed, see sim.log"; exit 1; }

//--- sim/na_tb.sv
/*
 * Network adapter testbench: bus windows, send and receive paths, interrupt
 * Expected values come from the address map and the packet rules
 */

`timescale 1ns/1ps

module na_tb;

   import na_pkg::*;

   localparam logic [31:0] TB_TILE_ID   = 32'h0000_0023;
   localparam logic [31:0] TB_CORE_BASE = 32'h8000_0000;
   localparam logic [31:0] SEED         = 32'hc877a7c0;
   localparam int          BUS_LIMIT    = 50;    // Cycles allowed for ack or err
   localparam int          LINK_LIMIT   = 50;
   localparam int          FLIT_LIMIT   = 200;

   logic      clk;
   logic      reset;
   wb_req_t   wb_req;
   wb_rsp_t   wb_rsp;
   noc_flit_t noc_in_flit;
   logic      noc_in_valid;
   logic      noc_in_ready;
   noc_flit_t noc_out_flit;
   logic      noc_out_valid;
   logic      noc_out_ready;
   logic      irq;

   logic [31:0] pay_state;    // Payload stream
   noc_flit_t   got_q[$];     // Flits that left noc_out
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          test_start_errors;

   na_top #(
      .TILE_ID    (TB_TILE_ID),
      .CORE_BASE  (TB_CORE_BASE),
      .BUF_DEPTH  (4),
      .RECV_DEPTH (16)
   ) na_top_i (
      .clk_i           (clk),
      .reset_i         (reset),
      .wb_req_i        (wb_req),
      .wb_rsp_o        (wb_rsp),
      .noc_in_flit_i   (noc_in_flit),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_flit_o  (noc_out_flit),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .irq_o           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic wb_addr_t win_addr(input win_sel_t win, input wb_addr_t offs);
      return {win, offs[19:0]};
   endfunction

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout: %s did not complete in time", what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic begin_test();
      test_start_errors = errors;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_start_errors) begin
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: %0d errors", name, errors - test_start_errors);
      end
   endtask

   // One bus access, held until ack or err, then one idle cycle
   task automatic bus_cycle(input wb_addr_t adr, input wb_data_t wdat, input logic we,
                            output wb_data_t rdat, output logic ack, output logic err,
                            output int lat);
      int cycles;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      @(negedge clk);
      cycles = 1;
      while (!wb_rsp.ack && !wb_rsp.err && cycles < BUS_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!wb_rsp.ack && !wb_rsp.err) begin
         timeout_fail("bus access");
      end else begin
         rdat   = wb_rsp.dat;
         ack    = wb_rsp.ack;
         err    = wb_rsp.err;
         lat    = cycles;
         wb_req = '0;
         @(negedge clk);
      end
   endtask

   task automatic inject_flit(input noc_flit_t f);
      int cycles;
      noc_in_flit  = f;
      noc_in_valid = 1'b1;
      cycles       = 0;
      while (!noc_in_ready && cycles < LINK_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!noc_in_ready) begin
         timeout_fail("input link transfer");
      end else begin
         @(negedge clk);   // Taken on the rising edge in between
         noc_in_valid = 1'b0;
      end
   endtask

   task automatic wait_out_flits(input int n);
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (got_q.size() < n && cycles < FLIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (got_q.size() < n)
         timeout_fail("output link packet");
      else
         @(negedge clk);
   endtask

   // Output link sink with random back-pressure
   initial begin : link_sink
      logic [31:0] rdy_state;
      logic        rdy;
      rdy_state     = SEED;
      noc_out_ready = 1'b0;
      forever begin
         @(negedge clk);
         rdy_state     = xorshift32(rdy_state);
         rdy           = rdy_state[7];
         noc_out_ready = rdy;
         if (noc_out_valid && rdy)
            got_q.push_back(noc_out_flit);   // Transfers at the next rising edge
      end
   end

   initial begin : main_seq
      wb_data_t    rdat;
      logic        ack;
      logic        err;
      int          lat;
      int          polls;
      logic [31:0] status;
      logic [31:0] sent [5];
      logic [31:0] rx_words [3];
      noc_flit_t   f;

      reset        = 1'b1;
      wb_req       = '0;
      noc_in_flit  = '0;
      noc_in_valid = 1'b0;
      pay_state    = SEED;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;

      begin_test();
      repeat (10) begin
         @(negedge clk);
         assert (!noc_out_valid && !wb_rsp.ack && !wb_rsp.err && !irq && !noc_in_ready)
            else report_error("Output active during reset");
      end
      reset = 1'b0;
      @(negedge clk);
      assert (!noc_out_valid && !wb_rsp.ack && !wb_rsp.err && !irq)
         else report_error("Output active in the first cycle after reset");
      assert (noc_in_ready) else report_error("noc_in ready did not rise after reset");
      end_test("reset");

      begin_test();
      bus_cycle(win_addr(WIN_CONF, REG_TILEID), '0, 1'b0, rdat, ack, err, lat);
      assert (ack && !err && rdat == TB_TILE_ID)
         else report_error($sformatf("Tile id read %h, expected %h", rdat, TB_TILE_ID));
      assert (lat == 1) else report_error($sformatf("Tile id ack after %0d cycles", lat));
      bus_cycle(win_addr(WIN_CONF, REG_COREBASE), '0, 1'b0, rdat, ack, err, lat);
      assert (ack && !err && rdat == TB_CORE_BASE)
         else report_error($sformatf("Core base read %h, expected %h", rdat, TB_CORE_BASE));
      assert (lat == 1) else report_error($sformatf("Core base ack after %0d cycles", lat));
      bus_cycle(win_addr(4'h3, 24'h0), '0, 1'b0, rdat, ack, err, lat);
      assert (err && !ack) else report_error("Unmapped window did not return err");
      assert (lat == 1) else report_error($sformatf("Unmapped err after %0d cycles", lat));
      end_test("config and decode");

      begin_test();
      bus_cycle(win_addr(WIN_MP, REG_MP_DATA), 32'd5, 1'b1, rdat, ack, err, lat);
      assert (ack && !err && lat == 1) else report_error("Length word 5 not acked in 1 cycle");
      for (int i = 0; i < 5; i++) begin
         pay_state = xorshift32(pay_state);
         sent[i]   = pay_state;
         bus_cycle(win_addr(WIN_MP, REG_MP_DATA), sent[i], 1'b1, rdat, ack, err, lat);
         assert (ack && !err) else report_error($sformatf("Send write %0d not acked", i));
      end
      wait_out_flits(5);
      for (int i = 0; i < 5; i++) begin
         assert (got_q[i].data == sent[i] && got_q[i].last == (i == 4))
            else report_error($sformatf("Flit %0d is %h last %b, expected %h last %b",
                                        i, got_q[i].data, got_q[i].last, sent[i], i == 4));
      end
      bus_cycle(win_addr(WIN_MP, REG_MP_DATA), 32'd0, 1'b1, rdat, ack, err, lat);
      assert (err && !ack && lat == 1) else report_error("Length word 0 did not return err");
      repeat (8) @(posedge clk);   // Window for a stray flit
      @(negedge clk);
      assert (got_q.size() == 5 && !noc_out_valid)
         else report_error($sformatf("%0d flits at noc_out after length 0, expected 5",
                                     got_q.size()));
      end_test("send");

      begin_test();
      for (int i = 0; i < 3; i++) begin
         pay_state   = xorshift32(pay_state);
         rx_words[i] = pay_state;
         f.data      = rx_words[i];
         f.last      = (i == 2);
         inject_flit(f);
      end
      status = '0;
      polls  = 0;
      while (status == 32'd0 && polls < 20) begin   // Flits still crossing the buffer
         bus_cycle(win_addr(WIN_MP, REG_MP_STATUS), '0, 1'b0, rdat, ack, err, lat);
         status = rdat;
         polls++;
      end
      assert (status == 32'd1) else report_error($sformatf("Status %0d, expected 1", status));
      assert (!irq) else report_error("irq high while disabled");
      bus_cycle(win_addr(WIN_CONF, REG_IRQ_EN), 32'd1, 1'b1, rdat, ack, err, lat);
      assert (ack && !err) else report_error("Interrupt enable write not acked");
      assert (irq) else report_error("irq low with a packet pending and enable set");
      for (int i = 0; i < 3; i++) begin
         bus_cycle(win_addr(WIN_MP, REG_MP_DATA), '0, 1'b0, rdat, ack, err, lat);
         assert (ack && !err && rdat == rx_words[i])
            else report_error($sformatf("Data read %0d is %h, expected %h",
                                        i, rdat, rx_words[i]));
      end
      bus_cycle(win_addr(WIN_MP, REG_MP_STATUS), '0, 1'b0, rdat, ack, err, lat);
      assert (ack && rdat == 32'd0) else report_error($sformatf("Status %0d, expected 0", rdat));
      assert (!irq) else report_error("irq high with no packet pending");
      end_test("receive and interrupt");

      begin_test();
      bus_cycle(win_addr(WIN_MP, REG_MP_DATA), '0, 1'b0, rdat, ack, err, lat);
      assert (err && !ack) else report_error("Read of an empty queue did not return err");
      end_test("empty receive queue");

      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
